// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_inst_window
FILELIST  ?= inst_window.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the simulator output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: hw/inst_window.sv
`timescale 1ns/1ps

module inst_window #(
    parameter int WINDOW_DEPTH = 8
) (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  d_done,
    input  iw_entry_pkg::decoded_inst_t                           d_inst,
    input  logic                                                  wb_valid,
    input  logic [iw_isa_pkg::PREG_W-1:0]                         wb_preg,
    input  logic                                                  branch_hazard,
    input  logic [iw_isa_pkg::CONTEXT_W-1:0]                      hazard_context,
    input  logic [iw_isa_pkg::NUM_EXEC_PORTS-1:0]                 accepted,
    output logic                                                  accept_able,
    output logic [iw_isa_pkg::NUM_EXEC_PORTS-1:0]                 order,
    output iw_entry_pkg::issue_t [iw_isa_pkg::NUM_EXEC_PORTS-1:0] issue_info
);

    import iw_isa_pkg::*;
    import iw_entry_pkg::*;

    localparam int SLOT_W = $clog2(WINDOW_DEPTH);

    window_entry_t                         new_entry;
    window_entry_t [WINDOW_DEPTH-1:0]      next_entries;
    logic [NUM_EXEC_PORTS-1:0][SLOT_W-1:0] order_slot;

    iw_dispatch u_dispatch (
        .d_done         (d_done),
        .d_inst         (d_inst),
        .wb_valid       (wb_valid),
        .wb_preg        (wb_preg),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .new_entry      (new_entry)
    );

    iw_window_store #(
        .WINDOW_DEPTH (WINDOW_DEPTH)
    ) u_window_store (
        .clk            (clk),
        .reset          (reset),
        .new_entry      (new_entry),
        .wb_valid       (wb_valid),
        .wb_preg        (wb_preg),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .order          (order),
        .order_slot     (order_slot),
        .accepted       (accepted),
        .next_entries   (next_entries),
        .accept_able    (accept_able)
    );

    iw_issue_select #(
        .WINDOW_DEPTH (WINDOW_DEPTH)
    ) u_issue_select (
        .clk          (clk),
        .reset        (reset),
        .next_entries (next_entries),
        .order        (order),
        .order_slot   (order_slot),
        .issue_info   (issue_info)
    );

endmodule

// File: hw/iw_dispatch.sv
`timescale 1ns/1ps

module iw_dispatch (
    input  logic                             d_done,
    input  iw_entry_pkg::decoded_inst_t      d_inst,
    input  logic                             wb_valid,
    input  logic [iw_isa_pkg::PREG_W-1:0]    wb_preg,
    input  logic                             branch_hazard,
    input  logic [iw_isa_pkg::CONTEXT_W-1:0] hazard_context,
    output iw_entry_pkg::window_entry_t      new_entry
);

    logic squashed;
    logic rs1_wake;
    logic rs2_wake;

    // a mispredict on this context kills the instruction before it lands
    assign squashed = branch_hazard & |(hazard_context & d_inst.ctx);

    // writeback in the same cycle counts as ready
    assign rs1_wake = wb_valid & (wb_preg == d_inst.ps1);
    assign rs2_wake = wb_valid & (wb_preg == d_inst.ps2);

    always_comb begin
        new_entry.valid     = d_done & ~squashed;
        new_entry.cls       = d_inst.cls;
        new_entry.func3     = d_inst.func3;
        new_entry.func7     = d_inst.func7;
        new_entry.imm       = d_inst.imm;
        new_entry.ps1       = d_inst.ps1;
        new_entry.ps2       = d_inst.ps2;
        new_entry.pd        = d_inst.pd;
        new_entry.rs1_ready = d_inst.rs1_ready | rs1_wake;
        new_entry.rs2_ready = d_inst.rs2_ready | rs2_wake;
        new_entry.ctx       = d_inst.ctx;
    end

endmodule

// File: hw/iw_entry_pkg.sv
package iw_entry_pkg;

    import iw_isa_pkg::*;

    // one instruction as it leaves the decoder
    typedef struct packed {
        exec_class_t          cls;
        logic [FUNC3_W-1:0]   func3;
        logic [FUNC7_W-1:0]   func7;
        logic [IMM_W-1:0]     imm;
        logic [PREG_W-1:0]    ps1;
        logic [PREG_W-1:0]    ps2;
        logic [PREG_W-1:0]    pd;
        logic                 rs1_ready;
        logic                 rs2_ready;
        logic [CONTEXT_W-1:0] ctx;
    } decoded_inst_t;

    // one window slot, ready bits track wakeups
    typedef struct packed {
        logic                 valid;
        exec_class_t          cls;
        logic [FUNC3_W-1:0]   func3;
        logic [FUNC7_W-1:0]   func7;
        logic [IMM_W-1:0]     imm;
        logic [PREG_W-1:0]    ps1;
        logic [PREG_W-1:0]    ps2;
        logic [PREG_W-1:0]    pd;
        logic                 rs1_ready;
        logic                 rs2_ready;
        logic [CONTEXT_W-1:0] ctx;
    } window_entry_t;

    // what an execution port gets with its order
    typedef struct packed {
        exec_class_t          cls;
        logic [FUNC3_W-1:0]   func3;
        logic [FUNC7_W-1:0]   func7;
        logic [IMM_W-1:0]     imm;
        logic [PREG_W-1:0]    pd;
        logic [PREG_W-1:0]    ps1;
        logic [PREG_W-1:0]    ps2;
        logic [CONTEXT_W-1:0] ctx;
    } issue_t;

endpackage

// File: hw/iw_isa_pkg.sv
package iw_isa_pkg;

    // execution ports of the core
    parameter int NUM_EXEC_PORTS = 3;

    // physical register tag and context mask
    parameter int PREG_W    = 6;
    parameter int CONTEXT_W = 4;

    // instruction payload fields
    parameter int IMM_W   = 32;
    parameter int FUNC3_W = 3;
    parameter int FUNC7_W = 7;

    // one-hot class flags, all zero when the decoder could not classify
    typedef struct packed {
        logic branch;
        logic mem;
        logic alu;
    } exec_class_t;

    // port numbers, also the bit index into order and accepted
    typedef enum logic [1:0] {
        PORT_BRANCH = 2'd0,
        PORT_MEM    = 2'd1,
        PORT_ALU    = 2'd2
    } exec_port_e;

endpackage

// File: hw/iw_issue_select.sv
`timescale 1ns/1ps

module iw_issue_select #(
    parameter  int WINDOW_DEPTH = 8,
    localparam int SLOT_W       = $clog2(WINDOW_DEPTH)
) (
    input  logic                                               clk,
    input  logic                                               reset,
    input  iw_entry_pkg::window_entry_t [WINDOW_DEPTH-1:0]     next_entries,
    output logic [iw_isa_pkg::NUM_EXEC_PORTS-1:0]              order,
    output logic [iw_isa_pkg::NUM_EXEC_PORTS-1:0][SLOT_W-1:0]  order_slot,
    output iw_entry_pkg::issue_t [iw_isa_pkg::NUM_EXEC_PORTS-1:0] issue_info
);

    import iw_isa_pkg::*;
    import iw_entry_pkg::*;

    // branch and memory ports keep program order within their class
    localparam logic [NUM_EXEC_PORTS-1:0] IN_ORDER_PORTS =
        NUM_EXEC_PORTS'((1 << PORT_BRANCH) | (1 << PORT_MEM));

    logic [WINDOW_DEPTH-1:0]               ready;
    logic [NUM_EXEC_PORTS-1:0]             port_of [WINDOW_DEPTH];
    logic [NUM_EXEC_PORTS-1:0]             pick;
    logic [NUM_EXEC_PORTS-1:0][SLOT_W-1:0] pick_slot;
    logic [NUM_EXEC_PORTS-1:0]             seen;
    logic                                  blocked;

    // unknown class shares port 0 with branches
    always_comb begin
        for (int i = 0; i < WINDOW_DEPTH; i++) begin
            port_of[i][PORT_BRANCH] = next_entries[i].cls.branch | ~|next_entries[i].cls;
            port_of[i][PORT_MEM]    = next_entries[i].cls.mem & ~port_of[i][PORT_BRANCH];
            port_of[i][PORT_ALU]    = ~port_of[i][PORT_BRANCH] & ~port_of[i][PORT_MEM];

            ready[i] = next_entries[i].valid
                     & next_entries[i].rs1_ready
                     & next_entries[i].rs2_ready
                     & |next_entries[i].cls;
        end
    end

    // oldest first; an in-order port stops at the first entry of its class
    always_comb begin
        pick      = '0;
        pick_slot = '0;
        seen      = '0;
        blocked   = 1'b0;
        for (int i = 0; i < WINDOW_DEPTH; i++) begin
            if (next_entries[i].valid) begin
                for (int p = 0; p < NUM_EXEC_PORTS; p++) begin
                    if (port_of[i][p] && ready[i] && !seen[p] && !blocked) begin
                        pick[p]      = 1'b1;
                        pick_slot[p] = SLOT_W'(i);
                    end
                end
                seen = seen | (port_of[i] & (IN_ORDER_PORTS | {NUM_EXEC_PORTS{ready[i]}}));
                // nothing younger than a pending port-0 entry may go
                blocked = blocked | port_of[i][PORT_BRANCH];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            order      <= '0;
            order_slot <= '0;
        end else begin
            order      <= pick;
            order_slot <= pick_slot;
        end
    end

    // payload follows the chosen slot every cycle
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_EXEC_PORTS; p++) begin
            issue_info[p].cls   <= next_entries[pick_slot[p]].cls;
            issue_info[p].func3 <= next_entries[pick_slot[p]].func3;
            issue_info[p].func7 <= next_entries[pick_slot[p]].func7;
            issue_info[p].imm   <= next_entries[pick_slot[p]].imm;
            issue_info[p].pd    <= next_entries[pick_slot[p]].pd;
            issue_info[p].ps1   <= next_entries[pick_slot[p]].ps1;
            issue_info[p].ps2   <= next_entries[pick_slot[p]].ps2;
            issue_info[p].ctx   <= next_entries[pick_slot[p]].ctx;
        end
    end

endmodule

// File: hw/iw_window_store.sv
`timescale 1ns/1ps

module iw_window_store #(
    parameter  int WINDOW_DEPTH = 8,
    localparam int SLOT_W       = $clog2(WINDOW_DEPTH)
) (
    input  logic                                               clk,
    input  logic                                               reset,
    input  iw_entry_pkg::window_entry_t                        new_entry,
    input  logic                                               wb_valid,
    input  logic [iw_isa_pkg::PREG_W-1:0]                      wb_preg,
    input  logic                                               branch_hazard,
    input  logic [iw_isa_pkg::CONTEXT_W-1:0]                   hazard_context,
    input  logic [iw_isa_pkg::NUM_EXEC_PORTS-1:0]              order,
    input  logic [iw_isa_pkg::NUM_EXEC_PORTS-1:0][SLOT_W-1:0]  order_slot,
    input  logic [iw_isa_pkg::NUM_EXEC_PORTS-1:0]              accepted,
    output iw_entry_pkg::window_entry_t [WINDOW_DEPTH-1:0]     next_entries,
    output logic                                               accept_able
);

    import iw_isa_pkg::*;
    import iw_entry_pkg::*;

    // slot 0 holds the oldest instruction
    window_entry_t [WINDOW_DEPTH-1:0] entries;
    window_entry_t [WINDOW_DEPTH-1:0] kept;
    window_entry_t [WINDOW_DEPTH-1:0] compact;

    logic [WINDOW_DEPTH-1:0] taken;
    logic [WINDOW_DEPTH-1:0] squash;
    logic [WINDOW_DEPTH-1:0] keep;
    logic [WINDOW_DEPTH-1:0] used;
    logic [WINDOW_DEPTH-1:0] first_free;
    logic [WINDOW_DEPTH-1:0] prefix_tbl [WINDOW_DEPTH];
    logic [WINDOW_DEPTH-1:0] src_onehot [WINDOW_DEPTH];

    // drop accepted and squashed entries, apply wakeup to the rest
    always_comb begin
        taken = '0;
        for (int i = 0; i < WINDOW_DEPTH; i++) begin
            for (int p = 0; p < NUM_EXEC_PORTS; p++) begin
                if (order[p] && accepted[p] && order_slot[p] == SLOT_W'(i)) begin
                    taken[i] = 1'b1;
                end
            end
            squash[i] = branch_hazard & |(hazard_context & entries[i].ctx);
            keep[i]   = entries[i].valid & ~taken[i] & ~squash[i];

            kept[i]           = entries[i];
            kept[i].valid     = keep[i];
            kept[i].rs1_ready = entries[i].rs1_ready
                              | (wb_valid & (entries[i].ps1 == wb_preg));
            kept[i].rs2_ready = entries[i].rs2_ready
                              | (wb_valid & (entries[i].ps2 == wb_preg));
        end
    end

    // prefix_tbl[k][j] is set once slots 0..j hold more than k survivors
    always_comb begin
        prefix_tbl[0][0] = keep[0];
        for (int j = 1; j < WINDOW_DEPTH; j++) begin
            prefix_tbl[0][j] = prefix_tbl[0][j-1] | keep[j];
        end
        for (int k = 1; k < WINDOW_DEPTH; k++) begin
            prefix_tbl[k][0] = 1'b0;
            for (int j = 1; j < WINDOW_DEPTH; j++) begin
                prefix_tbl[k][j] = prefix_tbl[k][j-1]
                                 | (prefix_tbl[k-1][j-1] & keep[j]);
            end
        end
    end

    // rising edge of each row names the source slot for position k
    always_comb begin
        for (int k = 0; k < WINDOW_DEPTH; k++) begin
            src_onehot[k] = prefix_tbl[k] ^ (prefix_tbl[k] << 1);
            used[k]       = |src_onehot[k];
            compact[k]    = '0;
            for (int j = 0; j < WINDOW_DEPTH; j++) begin
                if (src_onehot[k][j]) begin
                    compact[k] = kept[j];
                end
            end
        end
    end

    // used is a thermometer, so only one position qualifies
    assign first_free = ~used & {used[WINDOW_DEPTH-2:0], 1'b1};

    // new instruction goes right behind the survivors
    always_comb begin
        next_entries = compact;
        for (int k = 0; k < WINDOW_DEPTH; k++) begin
            if (first_free[k]) begin
                next_entries[k] = new_entry;
            end
        end
    end

    always_ff @(posedge clk) begin
        entries <= next_entries;
        if (reset) begin
            for (int i = 0; i < WINDOW_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end
    end

    // room for one more as long as the last slot stays empty
    always_ff @(posedge clk) begin
        if (reset) begin
            accept_able <= 1'b1;
        end else begin
            accept_able <= ~next_entries[WINDOW_DEPTH-1].valid;
        end
    end

endmodule

// File: inst_window.f
hw/iw_isa_pkg.sv
hw/iw_entry_pkg.sv
hw/iw_dispatch.sv
hw/iw_window_store.sv
hw/iw_issue_select.sv
hw/inst_window.sv
verification/inst_window_asserts.sv
verification/tb_inst_window.sv

// File: verification/inst_window_asserts.sv
`timescale 1ns/1ps

module inst_window_asserts (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  d_done,
    input  logic                                                  accept_able,
    input  logic                                                  wb_valid,
    input  logic                                                  branch_hazard,
    input  logic [iw_isa_pkg::NUM_EXEC_PORTS-1:0]                 order,
    input  logic [iw_isa_pkg::NUM_EXEC_PORTS-1:0]                 accepted,
    input  iw_entry_pkg::issue_t [iw_isa_pkg::NUM_EXEC_PORTS-1:0] issue_info
);

    import iw_isa_pkg::*;

    // decoder may only hand over an instruction when there is room
    decode_needs_room: assert property (@(posedge clk) disable iff (reset)
        d_done |-> accept_able)
        else $error("d_done high while accept_able is low");

    order_idle_after_reset: assert property (@(posedge clk)
        reset |=> order == '0)
        else $error("order not cleared after reset");

    // a refused order keeps naming the same entry unless wakeup or squash intervene
    for (genvar p = 0; p < NUM_EXEC_PORTS; p++) begin : g_port
        held_order_stable: assert property (@(posedge clk) disable iff (reset)
            (order[p] && !accepted[p] && !wb_valid && !branch_hazard)
            |=> (order[p] && $stable(issue_info[p])))
            else $error("port %0d dropped or changed a held order", p);
    end

endmodule

bind inst_window inst_window_asserts asserts_i (
    .clk           (clk),
    .reset         (reset),
    .d_done        (d_done),
    .accept_able   (accept_able),
    .wb_valid      (wb_valid),
    .branch_hazard (branch_hazard),
    .order         (order),
    .accepted      (accepted),
    .issue_info    (issue_info)
);

// File: verification/inst_window_stimulus.txt
# inputs: d_done cls ps1 ps2 pd rs1_ready rs2_ready ctx wb_valid wb_preg hazard hazard_ctx accepted
# expected in the same cycle: accept_able order pd_port0 pd_port1 pd_port2 (all hex)
1 1 00 00 10 1 1 1  0 00  0 0  0   1 0 00 00 00
0 0 00 00 00 0 0 0  0 00  0 0  4   1 4 00 00 10
0 0 00 00 00 0 0 0  0 00  0 0  0   1 0 00 00 00
1 1 21 22 11 0 1 1  0 00  0 0  0   1 0 00 00 00
1 1 00 00 12 1 1 1  0 00  0 0  0   1 0 00 00 00
0 0 00 00 00 0 0 0  0 00  0 0  4   1 4 00 00 12
0 0 00 00 00 0 0 0  1 21  0 0  0   1 0 00 00 00
0 0 00 00 00 0 0 0  0 00  0 0  4   1 4 00 00 11
1 4 23 00 13 0 1 2  0 00  0 0  0   1 0 00 00 00
1 1 00 00 14 1 1 2  0 00  0 0  0   1 0 00 00 00
1 2 00 00 15 1 1 2  0 00  0 0  0   1 0 00 00 00
0 0 00 00 00 0 0 0  1 23  0 0  0   1 0 00 00 00
0 0 00 00 00 0 0 0  0 00  0 0  1   1 1 13 00 00
0 0 00 00 00 0 0 0  0 00  0 0  6   1 6 00 15 14
1 0 00 00 16 1 1 4  0 00  0 0  0   1 0 00 00 00
1 1 00 00 17 1 1 4  0 00  0 0  0   1 0 00 00 00
0 0 00 00 00 0 0 0  0 00  0 0  0   1 0 00 00 00
1 2 28 00 18 0 1 1  0 00  0 0  0   1 0 00 00 00
1 2 00 00 19 1 1 8  0 00  0 0  0   1 0 00 00 00
1 1 00 00 1a 1 1 4  0 00  1 4  0   1 0 00 00 00
0 0 00 00 00 0 0 0  1 28  0 0  0   1 0 00 00 00
0 0 00 00 00 0 0 0  0 00  0 0  2   1 2 00 18 00
0 0 00 00 00 0 0 0  0 00  0 0  2   1 2 00 19 00
0 0 00 00 00 0 0 0  0 00  0 0  0   1 0 00 00 00
1 1 00 00 20 1 1 1  0 00  0 0  0   1 0 00 00 00
1 1 00 00 21 1 1 1  0 00  0 0  0   1 4 00 00 20
1 1 00 00 22 1 1 1  0 00  0 0  0   1 4 00 00 20
1 1 00 00 23 1 1 1  0 00  0 0  0   1 4 00 00 20
1 1 00 00 24 1 1 1  0 00  0 0  0   1 4 00 00 20
1 1 00 00 25 1 1 1  0 00  0 0  0   1 4 00 00 20
1 1 00 00 26 1 1 1  0 00  0 0  0   1 4 00 00 20
1 1 00 00 27 1 1 1  0 00  0 0  0   1 4 00 00 20
0 0 00 00 00 0 0 0  0 00  0 0  0   0 4 00 00 20
0 0 00 00 00 0 0 0  0 00  0 0  0   0 4 00 00 20
0 0 00 00 00 0 0 0  0 00  0 0  4   0 4 00 00 20
0 0 00 00 00 0 0 0  0 00  0 0  0   1 4 00 00 21

// File: verification/tb_inst_window.sv
`timescale 1ns/1ps

module tb_inst_window;

    import iw_isa_pkg::*;
    import iw_entry_pkg::*;

    logic                        clk;
    logic                        reset;
    logic                        d_done;
    decoded_inst_t               d_inst;
    logic                        wb_valid;
    logic [PREG_W-1:0]           wb_preg;
    logic                        branch_hazard;
    logic [CONTEXT_W-1:0]        hazard_context;
    logic [NUM_EXEC_PORTS-1:0]   accepted;
    logic                        accept_able;
    logic [NUM_EXEC_PORTS-1:0]   order;
    issue_t [NUM_EXEC_PORTS-1:0] issue_info;

    // every instruction handed to the window, looked up by its destination tag
    decoded_inst_t               sent [2**PREG_W];

    inst_window #(
        .WINDOW_DEPTH (8)
    ) inst_window_i (
        .clk            (clk),
        .reset          (reset),
        .d_done         (d_done),
        .d_inst         (d_inst),
        .wb_valid       (wb_valid),
        .wb_preg        (wb_preg),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .accepted       (accepted),
        .accept_able    (accept_able),
        .order          (order),
        .issue_info     (issue_info)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "%s", reason);
    endtask

    // immediate tagged with the destination so the payload can be traced
    function automatic logic [31:0] imm_for(input logic [31:0] pd);
        return 32'h0000_1000 + pd;
    endfunction

    // one-hot class that each port is allowed to carry
    function automatic logic [2:0] port_class(input int p);
        exec_class_t cls;
        cls.branch = (p == 0);
        cls.mem    = (p == 1);
        cls.alu    = (p == 2);
        return cls;
    endfunction

    initial begin
        int            fd;
        int            fields;
        int            vectors;
        string         line;
        decoded_inst_t exp_inst;
        logic [31:0]   v_dd, v_cls, v_ps1, v_ps2, v_pd, v_r1, v_r2, v_ctx;
        logic [31:0]   v_wb, v_wpreg, v_bh, v_hctx, v_acc, v_aa, v_ord;
        logic [31:0]   exp_pd [NUM_EXEC_PORTS];

        reset          = 1'b1;
        d_done         = 1'b0;
        d_inst         = '0;
        wb_valid       = 1'b0;
        wb_preg        = '0;
        branch_hazard  = 1'b0;
        hazard_context = '0;
        accepted       = '0;
        vectors        = 0;

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("order", 32'(order), 32'd0);
        check_value("accept_able", 32'(accept_able), 32'd1);

        fd = $fopen("verification/inst_window_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_error("could not open the stimulus file");
        end

        // one vector per cycle, driven 1 ns after the edge, checked 1 ns before the next
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             v_dd, v_cls, v_ps1, v_ps2, v_pd, v_r1, v_r2, v_ctx,
                             v_wb, v_wpreg, v_bh, v_hctx, v_acc, v_aa, v_ord,
                             exp_pd[0], exp_pd[1], exp_pd[2]);
            if (fields != 18) begin
                stop_with_error($sformatf("malformed stimulus line: %s", line));
            end

            d_done           = v_dd[0];
            d_inst           = '0;
            d_inst.cls       = exec_class_t'(v_cls[2:0]);
            // function fields also tagged from the destination
            d_inst.func3     = v_pd[FUNC3_W-1:0];
            d_inst.func7     = v_pd[FUNC7_W-1:0] ^ 7'h55;
            d_inst.ps1       = v_ps1[PREG_W-1:0];
            d_inst.ps2       = v_ps2[PREG_W-1:0];
            d_inst.pd        = v_pd[PREG_W-1:0];
            d_inst.imm       = imm_for(v_pd);
            d_inst.rs1_ready = v_r1[0];
            d_inst.rs2_ready = v_r2[0];
            d_inst.ctx       = v_ctx[CONTEXT_W-1:0];
            wb_valid         = v_wb[0];
            wb_preg          = v_wpreg[PREG_W-1:0];
            branch_hazard    = v_bh[0];
            hazard_context   = v_hctx[CONTEXT_W-1:0];
            accepted         = v_acc[NUM_EXEC_PORTS-1:0];
            if (d_done) begin
                sent[v_pd[PREG_W-1:0]] = d_inst;
            end

            #18;
            check_value("accept_able", 32'(accept_able), v_aa);
            check_value("order", 32'(order), v_ord);
            for (int p = 0; p < NUM_EXEC_PORTS; p++) begin
                if (v_ord[p]) begin
                    exp_inst = sent[exp_pd[p][PREG_W-1:0]];
                    check_value($sformatf("issue_info[%0d].pd", p),
                                32'(issue_info[p].pd), exp_pd[p]);
                    check_value($sformatf("issue_info[%0d].imm", p),
                                32'(issue_info[p].imm), imm_for(exp_pd[p]));
                    check_value($sformatf("issue_info[%0d].cls", p),
                                32'(issue_info[p].cls), 32'(port_class(p)));
                    check_value($sformatf("issue_info[%0d].func3", p),
                                32'(issue_info[p].func3), 32'(exp_inst.func3));
                    check_value($sformatf("issue_info[%0d].func7", p),
                                32'(issue_info[p].func7), 32'(exp_inst.func7));
                    check_value($sformatf("issue_info[%0d].ps1", p),
                                32'(issue_info[p].ps1), 32'(exp_inst.ps1));
                    check_value($sformatf("issue_info[%0d].ps2", p),
                                32'(issue_info[p].ps2), 32'(exp_inst.ps2));
                    check_value($sformatf("issue_info[%0d].ctx", p),
                                32'(issue_info[p].ctx), 32'(exp_inst.ctx));
                end
            end
            vectors++;
            @(posedge clk);
            #1;
        end
        $fclose(fd);

        if (vectors == 0) begin
            $display("no vectors were found in the stimulus file");
            $display("TEST FAILED");
            $fatal(1, "empty stimulus");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule
